// File: filelist.f
+incdir+sim
rtl/mcu_cmd_pkg.sv
rtl/spi_slave.sv
rtl/cmd_decoder.sv
rtl/flag_bank.sv
rtl/reply_mux.sv
rtl/clk_freq_meter.sv
rtl/mcu_cmd_top.sv
sim/tb_mcu_cmd.sv

// File: run_sim.sh
#!/bin/sh
# build and run the mcu_cmd testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f filelist.f \
  --top-module tb_mcu_cmd -o tb_mcu_cmd
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_mcu_cmd > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "TEST PASSED" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1

// File: sim/test_input.txt
# name, flag_event hex, byte count n, n frame bytes, n expected miso bytes
# (-- not checked, mm from memory model), check count, port/value pairs in hex
reset_state 0000 0 8
  mapper 1 rom_mask 0 save_mask 0 features 0
  addr 0 flags 0 rrq_count 0 wrq_count 0
mapper 0000 1 35 00 1 mapper 5
rom_mask 0000 4 10 3f ff ff 00 00 00 00
  2 rom_mask 3fffff mapper 5
save_mask 0000 4 20 00 1f ff 00 00 00 00
  2 save_mask 001fff rom_mask 3fffff
features 0000 2 ed 81 00 00 1 features 81
get_id 0000 4 f0 00 00 00 00 a5 a5 a5 0
echo 0000 4 ff 11 22 33 00 -- 11 22 0
set_addr 0000 4 00 12 34 40 00 00 00 00 1 addr 123440
write_inc 0000 4 98 11 22 33 00 00 00 00
  2 addr 123443 wrq_count 3
set_addr_again 0000 4 00 12 34 40 00 00 00 00 1 addr 123440
read_inc 0000 6 88 00 00 00 00 00 00 -- 11 22 33 mm
  2 addr 123446 rrq_count 6
set_addr_low 0000 4 00 12 34 50 00 00 00 00 1 addr 123450
read_fixed 0000 3 80 00 00 00 -- mm
  2 addr 123450 rrq_count 3
flag_events 8421 0 1 flags 8421
clear_bank1 0000 3 c1 00 04 00 00 00 1 flags 8021
set_bank0 0000 3 c0 02 01 00 00 00 1 flags 8022
get_flags 0000 5 f1 00 00 00 00 00 22 80 00 00 0
get_freq 0000 5 fe 00 00 00 00 00 -- -- -- -- 1 freq e8

// File: sim/spi_master_tasks.svh
`ifndef SPI_MASTER_TASKS_SVH
`define SPI_MASTER_TASKS_SVH

////////////////////////////////////////////////////////////////////////////
// spi master, mode 0, msb first
////////////////////////////////////////////////////////////////////////////

// drive point, a little after the rising clk edge
task automatic tick();
  @(posedge clk);
  #10;
endtask

// 4 clk low then 4 clk high per bit, 8 clk per bit in total
task automatic xfer_byte(input logic [7:0] tx, output logic [7:0] rx);
  for (int i = 7; i >= 0; i--) begin
    sck  = 1'b0;
    mosi = tx[i];
    repeat (4) tick();
    sck = 1'b1;
    repeat (4) tick();
    // miso has been stable since the last falling edge
    rx[i] = miso;
  end
endtask

// frame_tx[0..n-1] out, frame_rx[0..n-1] back
task automatic send_frame(input int n);
  logic [7:0] rx;
  ss_n = 1'b0;
  repeat (2) tick();
  for (int b = 0; b < n; b++) begin
    xfer_byte(frame_tx[b], rx);
    frame_rx[b] = rx;
  end
  sck = 1'b0;
  repeat (2) tick();
  ss_n = 1'b1;
  mosi = 1'b0;
endtask

`endif

// File: sim/tb_mcu_cmd.sv
`timescale 1ns/1ns

module tb_mcu_cmd;
  import mcu_cmd_pkg::*;

  localparam int FRAME_MAX = 16;

  logic                        clk;
  logic                        sysclk;
  logic                        reset;
  logic                        sck;
  logic                        mosi;
  logic                        ss_n;
  logic                        miso;
  logic                        mem_rrq;
  logic                        mem_wrq;
  logic                        mem_rq_rdy;
  logic [7:0]                  mem_data_in;
  logic [7:0]                  mem_data_out;
  logic [ADDR_W-1:0]           addr;
  logic [2:0]                  mapper;
  logic [ADDR_W-1:0]           rom_mask;
  logic [ADDR_W-1:0]           save_mask;
  logic [7:0]                  feature_bits;
  logic [NUM_FLAG_BANKS*8-1:0] flag_event;
  logic [NUM_FLAG_BANKS*8-1:0] flags;

  logic [7:0] mem_model [0:255];
  logic [7:0] frame_tx [0:FRAME_MAX-1];
  logic [7:0] frame_rx [0:FRAME_MAX-1];
  logic [7:0] req_addr;
  int         rrq_count;
  int         wrq_count;
  int         seed;
  int         errors;
  int         step_errors;
  int         total_bytes;
  bit         steps_loaded;

  // steps as read from the data file
  string                       step_name [$];
  logic [NUM_FLAG_BANKS*8-1:0] step_event [$];
  int                          step_len [$];
  int                          step_checks [$];
  logic [7:0]                  frame_q [$];
  string                       reply_q [$];
  string                       port_q [$];
  logic [31:0]                 value_q [$];

  mcu_cmd_top u_dut (.*);

  `include "spi_master_tasks.svh"

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    sysclk = 1'b0;
    forever #215 sysclk = ~sysclk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // memory model, answers 2 cycles after a request
  ////////////////////////////////////////////////////////////////////////////
  always @(negedge clk) begin
    if (mem_rrq || mem_wrq) begin
      req_addr = addr[7:0];
      if (mem_wrq) begin
        mem_model[req_addr] = mem_data_out;
        wrq_count++;
      end else begin
        rrq_count++;
      end
      repeat (2) @(posedge clk);
      #10;
      mem_data_in = mem_model[req_addr];
      mem_rq_rdy  = 1'b1;
      @(posedge clk);
      #10;
      mem_rq_rdy = 1'b0;
    end
  end

  task automatic load_steps(output bit ok);
    int          fd;
    int          n;
    int          k;
    string       tok;
    string       line;
    logic [31:0] v;
    ok = 1'b0;
    fd = $fopen("sim/test_input.txt", "r");
    if (fd == 0) begin
      $display("cannot open the step file sim/test_input.txt");
      return;
    end
    while ($fscanf(fd, "%s", tok) == 1) begin
      if (tok.getc(0) == "#") begin
        void'($fgets(line, fd));
        continue;
      end
      void'($fscanf(fd, "%h %d", v, n));
      if (n > FRAME_MAX) begin
        $display("step %s has a frame longer than %0d bytes", tok, FRAME_MAX);
        return;
      end
      step_name.push_back(tok);
      step_event.push_back(v[NUM_FLAG_BANKS*8-1:0]);
      step_len.push_back(n);
      total_bytes += n;
      for (int i = 0; i < n; i++) begin
        void'($fscanf(fd, "%h", v));
        frame_q.push_back(v[7:0]);
      end
      for (int i = 0; i < n; i++) begin
        void'($fscanf(fd, "%s", tok));
        reply_q.push_back(tok);
      end
      void'($fscanf(fd, "%d", k));
      step_checks.push_back(k);
      for (int i = 0; i < k; i++) begin
        void'($fscanf(fd, "%s %h", tok, v));
        port_q.push_back(tok);
        value_q.push_back(v);
      end
    end
    $fclose(fd);
    ok = 1'b1;
  endtask

  function automatic logic [31:0] port_value(input string name, output bit known);
    known = 1'b1;
    case (name)
      "mapper":    return 32'(mapper);
      "rom_mask":  return 32'(rom_mask);
      "save_mask": return 32'(save_mask);
      "features":  return 32'(feature_bits);
      "addr":      return 32'(addr);
      "flags":     return 32'(flags);
      "rrq_count": return rrq_count;
      "wrq_count": return wrq_count;
      // count sent msb first on bytes 2 to 5
      "freq":      return {frame_rx[1], frame_rx[2], frame_rx[3], frame_rx[4]};
      default: begin
        known = 1'b0;
        return 32'h0;
      end
    endcase
  endfunction

  task automatic check_value(input string sig, input logic [31:0] exp,
                             input logic [31:0] act);
    if (act !== exp) begin
      $display("ERROR t=%0t %s expected %0h got %0h", $time, sig, exp, act);
      step_errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // sequencer
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    bit          ok;
    bit          known;
    int          fp;
    int          cp;
    logic [7:0]  start_low;
    logic [31:0] exp;
    logic [31:0] act;
    reset       = 1'b1;
    sck         = 1'b0;
    mosi        = 1'b0;
    ss_n        = 1'b1;
    mem_rq_rdy  = 1'b0;
    mem_data_in = 8'h00;
    flag_event  = '0;
    seed        = 19283;
    for (int i = 0; i < 256; i++) begin
      mem_model[i] = 8'($random(seed));
    end
    load_steps(ok);
    if (!ok) begin
      $display("TEST FAILED");
      $finish;
    end else begin
      steps_loaded = 1'b1;
      repeat (10) @(posedge clk);
      #10;
      reset = 1'b0;
      fp = 0;
      cp = 0;
      for (int s = 0; s < step_name.size(); s++) begin
        step_errors = 0;
        if (step_event[s] != '0) begin
          flag_event = step_event[s];
          tick();
          flag_event = '0;
        end
        start_low = addr[7:0];
        for (int j = 0; j < step_len[s]; j++) begin
          frame_tx[j] = frame_q[fp + j];
        end
        if (step_len[s] > 0) begin
          send_frame(step_len[s]);
        end
        // ready, register update and memory answer are all done by now
        repeat (8) tick();
        for (int j = 0; j < step_len[s]; j++) begin
          if (reply_q[fp + j] != "--") begin
            if (reply_q[fp + j] == "mm") begin
              // request on byte k shows up on byte k+2
              exp = 32'(mem_model[8'(start_low + j - 2)]);
            end else begin
              void'($sscanf(reply_q[fp + j], "%h", exp));
            end
            check_value($sformatf("miso byte %0d", j + 1), exp, 32'(frame_rx[j]));
          end
        end
        fp += step_len[s];
        for (int c = 0; c < step_checks[s]; c++) begin
          act = port_value(port_q[cp], known);
          if (!known) begin
            $display("step %s names a port the testbench does not know: %s",
                     step_name[s], port_q[cp]);
            step_errors++;
          end else if (port_q[cp] == "freq") begin
            if ((act + 1 < value_q[cp]) || (act > value_q[cp] + 1)) begin
              $display("ERROR t=%0t freq expected %0h +-1 got %0h",
                       $time, value_q[cp], act);
              step_errors++;
            end
          end else begin
            check_value(port_q[cp], value_q[cp], act);
          end
          cp++;
        end
        rrq_count = 0;
        wrq_count = 0;
        errors += step_errors;
        $display("step %0d %s done, %0d errors", s, step_name[s], step_errors);
      end
      $display("%0d steps run, %0d errors", step_name.size(), errors);
      if (errors == 0) begin
        $display("TEST PASSED");
      end else begin
        $display("TEST FAILED");
      end
      $finish;
    end
  end

  // 800 ns per bit, plus slack for reset and gaps between frames
  initial begin
    wait (steps_loaded);
    #(longint'(total_bytes) * 8 * 800 + 50000);
    $display("watchdog expired before the last step finished");
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: rtl/mcu_cmd_top.sv
`timescale 1ns/1ns

module mcu_cmd_top (
  input  logic                                      clk,
  input  logic                                      reset,
  input  logic                                      sck,
  input  logic                                      mosi,
  input  logic                                      ss_n,
  output logic                                      miso,
  output logic                                      mem_rrq,
  output logic                                      mem_wrq,
  input  logic                                      mem_rq_rdy,
  input  logic [7:0]                                mem_data_in,
  output logic [7:0]                                mem_data_out,
  output logic [mcu_cmd_pkg::ADDR_W-1:0]            addr,
  output logic [2:0]                                mapper,
  output logic [mcu_cmd_pkg::ADDR_W-1:0]            rom_mask,
  output logic [mcu_cmd_pkg::ADDR_W-1:0]            save_mask,
  output logic [7:0]                                feature_bits,
  input  logic [mcu_cmd_pkg::NUM_FLAG_BANKS*8-1:0]  flag_event,
  output logic [mcu_cmd_pkg::NUM_FLAG_BANKS*8-1:0]  flags,
  input  logic                                      sysclk
);
  import mcu_cmd_pkg::*;

  logic                      cmd_ready;
  logic                      param_ready;
  cmd_word_t                 cmd_data;
  logic [7:0]                param_data;
  logic [BYTE_CNT_W-1:0]     byte_cnt;
  logic [7:0]                reply_data;
  logic                      mem_data_valid;
  logic [7:0]                flag_set_mask;
  logic [7:0]                flag_clear_mask;
  logic [NUM_FLAG_BANKS-1:0] flag_write;
  logic [FREQ_W-1:0]         freq_count;

  spi_slave u_spi (
    .clk         (clk),
    .reset       (reset),
    .sck         (sck),
    .mosi        (mosi),
    .ss_n        (ss_n),
    .miso        (miso),
    .reply_data  (reply_data),
    .cmd_ready   (cmd_ready),
    .param_ready (param_ready),
    .cmd_data    (cmd_data),
    .param_data  (param_data),
    .byte_cnt    (byte_cnt)
  );

  cmd_decoder u_decoder (
    .clk             (clk),
    .reset           (reset),
    .cmd_ready       (cmd_ready),
    .param_ready     (param_ready),
    .cmd_data        (cmd_data),
    .param_data      (param_data),
    .byte_cnt        (byte_cnt),
    .mem_rq_rdy      (mem_rq_rdy),
    .mem_rrq         (mem_rrq),
    .mem_wrq         (mem_wrq),
    .mem_data_out    (mem_data_out),
    .mem_data_valid  (mem_data_valid),
    .addr            (addr),
    .mapper          (mapper),
    .rom_mask        (rom_mask),
    .save_mask       (save_mask),
    .feature_bits    (feature_bits),
    .flag_set_mask   (flag_set_mask),
    .flag_clear_mask (flag_clear_mask),
    .flag_write      (flag_write)
  );

  for (genvar g = 0; g < NUM_FLAG_BANKS; g++) begin : g_bank
    flag_bank u_bank (
      .clk        (clk),
      .reset      (reset),
      .set_mask   (flag_set_mask),
      .clear_mask (flag_clear_mask),
      .write      (flag_write[g]),
      .flag_event (flag_event[g*8 +: 8]),
      .flags      (flags[g*8 +: 8])
    );
  end

  reply_mux u_reply (
    .clk            (clk),
    .reset          (reset),
    .cmd_ready      (cmd_ready),
    .param_ready    (param_ready),
    .cmd_data       (cmd_data),
    .param_data     (param_data),
    .byte_cnt       (byte_cnt),
    .mem_data_in    (mem_data_in),
    .mem_data_valid (mem_data_valid),
    .bank_flags     (flags),
    .freq_count     (freq_count),
    .reply_data     (reply_data)
  );

  clk_freq_meter u_meter (
    .clk        (clk),
    .reset      (reset),
    .sysclk     (sysclk),
    .freq_count (freq_count)
  );

endmodule

// File: rtl/clk_freq_meter.sv
`timescale 1ns/1ns

module clk_freq_meter (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              sysclk,
  output logic [mcu_cmd_pkg::FREQ_W-1:0]    freq_count
);
  import mcu_cmd_pkg::*;

  logic [2:0]             sys_sync;
  logic                   sys_rise;
  logic [FREQ_GATE_W-1:0] gate_cnt;
  logic [FREQ_W-1:0]      edge_cnt;

  assign sys_rise = sys_sync[1] & ~sys_sync[2];

  always_ff @(posedge clk) begin
    if (reset) begin
      sys_sync   <= 3'b000;
      gate_cnt   <= '0;
      edge_cnt   <= '0;
      freq_count <= '0;
    end else begin
      sys_sync <= {sys_sync[1:0], sysclk};
      if (gate_cnt == FREQ_GATE_W'(FREQ_GATE_CYCLES - 1)) begin
        // end of gate, publish and restart
        gate_cnt   <= '0;
        freq_count <= edge_cnt + FREQ_W'(sys_rise);
        edge_cnt   <= '0;
      end else begin
        gate_cnt <= gate_cnt + 1'b1;
        edge_cnt <= edge_cnt + FREQ_W'(sys_rise);
      end
    end
  end

endmodule

// File: rtl/reply_mux.sv
`timescale 1ns/1ns

module reply_mux (
  input  logic                                      clk,
  input  logic                                      reset,
  input  logic                                      cmd_ready,
  input  logic                                      param_ready,
  input  mcu_cmd_pkg::cmd_word_t                    cmd_data,
  input  logic [7:0]                                param_data,
  input  logic [mcu_cmd_pkg::BYTE_CNT_W-1:0]        byte_cnt,
  input  logic [7:0]                                mem_data_in,
  input  logic                                      mem_data_valid,
  input  logic [mcu_cmd_pkg::NUM_FLAG_BANKS*8-1:0]  bank_flags,
  input  logic [mcu_cmd_pkg::FREQ_W-1:0]            freq_count,
  output logic [7:0]                                reply_data
);
  import mcu_cmd_pkg::*;

  logic [FREQ_W-1:0] freq_snap;
  logic [7:0]        flag_sel;
  logic [7:0]        freq_sel;

  // bank k-1 at byte k, zero past the last bank
  always_comb begin
    flag_sel = 8'h00;
    for (int b = 0; b < NUM_FLAG_BANKS; b++) begin
      if (byte_cnt == BYTE_CNT_W'(b + 1)) begin
        flag_sel = bank_flags[b*8 +: 8];
      end
    end
  end

  // byte 1 reads the live count, the snapshot is taken on that same edge
  always_comb begin
    case (byte_cnt)
      1: freq_sel = freq_count[31:24];
      2: freq_sel = freq_snap[23:16];
      3: freq_sel = freq_snap[15:8];
      4: freq_sel = freq_snap[7:0];
      default: freq_sel = 8'h00;
    endcase
  end

  always_ff @(posedge clk) begin
    if (cmd_ready && (cmd_data.raw == CMD_GET_FREQ)) begin
      freq_snap <= freq_count;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      reply_data <= 8'h00;
    end else if (cmd_ready || param_ready) begin
      case (cmd_data.raw)
        CMD_GET_ID:    reply_data <= SPI_ID;
        CMD_ECHO:      reply_data <= param_data;
        CMD_GET_FLAGS: reply_data <= flag_sel;
        CMD_GET_FREQ:  reply_data <= freq_sel;
        default: begin
          // reads keep the last memory byte
          if (cmd_data.split.grp != GRP_MEM_READ) begin
            reply_data <= 8'h00;
          end
        end
      endcase
    end else if (mem_data_valid) begin
      reply_data <= mem_data_in;
    end
  end

endmodule

// File: rtl/flag_bank.sv
`timescale 1ns/1ns

module flag_bank (
  input  logic       clk,
  input  logic       reset,
  input  logic [7:0] set_mask,
  input  logic [7:0] clear_mask,
  input  logic       write,
  input  logic [7:0] flag_event,
  output logic [7:0] flags
);

  logic [7:0] flags_cmd;

  assign flags_cmd = write ? ((flags | set_mask) & ~clear_mask) : flags;

  // hardware events beat a clear in the same cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      flags <= 8'h00;
    end else begin
      flags <= flags_cmd | flag_event;
    end
  end

endmodule

// File: rtl/cmd_decoder.sv
`timescale 1ns/1ns

module cmd_decoder (
  input  logic                                    clk,
  input  logic                                    reset,
  input  logic                                    cmd_ready,
  input  logic                                    param_ready,
  input  mcu_cmd_pkg::cmd_word_t                  cmd_data,
  input  logic [7:0]                              param_data,
  input  logic [mcu_cmd_pkg::BYTE_CNT_W-1:0]      byte_cnt,
  input  logic                                    mem_rq_rdy,
  output logic                                    mem_rrq,
  output logic                                    mem_wrq,
  output logic [7:0]                              mem_data_out,
  output logic                                    mem_data_valid,
  output logic [mcu_cmd_pkg::ADDR_W-1:0]          addr,
  output logic [2:0]                              mapper,
  output logic [mcu_cmd_pkg::ADDR_W-1:0]          rom_mask,
  output logic [mcu_cmd_pkg::ADDR_W-1:0]          save_mask,
  output logic [7:0]                              feature_bits,
  output logic [7:0]                              flag_set_mask,
  output logic [7:0]                              flag_clear_mask,
  output logic [mcu_cmd_pkg::NUM_FLAG_BANKS-1:0]  flag_write
);
  import mcu_cmd_pkg::*;

  logic rdy_d;
  logic rdy_rise;
  logic mem_cmd;

  // bytes 2..4 of a frame, msb first
  function automatic logic [ADDR_W-1:0] fill_byte(
    input logic [ADDR_W-1:0]     old,
    input logic [BYTE_CNT_W-1:0] cnt,
    input logic [7:0]            data,
    input logic                  clear_low
  );
    logic [ADDR_W-1:0] val;
    val = old;
    case (cnt)
      2: val = clear_low ? {data, 16'h0000} : {data, old[15:0]};
      3: val[15:8] = data;
      4: val[7:0] = data;
      default: ;
    endcase
    return val;
  endfunction

  assign rdy_rise = mem_rq_rdy & ~rdy_d;
  assign mem_cmd  = (cmd_data.split.grp == GRP_MEM_READ) ||
                    (cmd_data.split.grp == GRP_MEM_WRITE);

  // read data is taken on the edge that ends the request
  assign mem_data_valid = rdy_rise && (cmd_data.split.grp == GRP_MEM_READ);

  always_ff @(posedge clk) begin
    if (reset) begin
      rdy_d           <= 1'b0;
      mem_rrq         <= 1'b0;
      mem_wrq         <= 1'b0;
      addr            <= '0;
      mapper          <= 3'd1;
      rom_mask        <= '0;
      save_mask       <= '0;
      feature_bits    <= 8'h00;
      flag_set_mask   <= 8'h00;
      flag_clear_mask <= 8'h00;
      flag_write      <= '0;
    end else begin
      rdy_d      <= mem_rq_rdy;
      mem_rrq    <= 1'b0;
      mem_wrq    <= 1'b0;
      flag_write <= '0;

      if (rdy_rise && mem_cmd && cmd_data.split.sub[INC_BIT]) begin
        addr <= addr + 1'b1;
      end

      if (cmd_ready) begin
        case (cmd_data.split.grp)
          GRP_MAPPER:   mapper <= cmd_data.split.sub[2:0];
          GRP_MEM_READ: mem_rrq <= 1'b1;
          default: ;
        endcase
      end else if (param_ready) begin
        case (cmd_data.split.grp)
          GRP_SET_ADDR:  addr <= fill_byte(addr, byte_cnt, param_data, 1'b1);
          GRP_ROM_MASK:  rom_mask <= fill_byte(rom_mask, byte_cnt, param_data, 1'b0);
          GRP_SAVE_MASK: save_mask <= fill_byte(save_mask, byte_cnt, param_data, 1'b0);
          GRP_MEM_READ:  mem_rrq <= 1'b1;
          GRP_MEM_WRITE: mem_wrq <= 1'b1;
          GRP_FLAGS: begin
            if (byte_cnt == 2) begin
              flag_set_mask <= param_data;
            end else if (byte_cnt == 3) begin
              flag_clear_mask <= param_data;
              // sub nibble selects the bank
              for (int b = 0; b < NUM_FLAG_BANKS; b++) begin
                flag_write[b] <= (cmd_data.split.sub == 4'(b));
              end
            end
          end
          default: begin
            if (cmd_data.raw == CMD_FEATURES) begin
              feature_bits <= param_data;
            end
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (param_ready && (cmd_data.split.grp == GRP_MEM_WRITE)) begin
      mem_data_out <= param_data;
    end
  end

endmodule

// File: rtl/spi_slave.sv
`timescale 1ns/1ns

module spi_slave (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                sck,
  input  logic                                mosi,
  input  logic                                ss_n,
  output logic                                miso,
  input  logic [7:0]                          reply_data,
  output logic                                cmd_ready,
  output logic                                param_ready,
  output mcu_cmd_pkg::cmd_word_t              cmd_data,
  output logic [7:0]                          param_data,
  output logic [mcu_cmd_pkg::BYTE_CNT_W-1:0]  byte_cnt
);
  import mcu_cmd_pkg::*;

  logic [2:0] sck_sync;
  logic [1:0] mosi_sync;
  logic [1:0] ss_sync;
  logic       active;
  logic       sck_rise;
  logic       sck_fall;
  logic [2:0] bit_cnt;
  logic [6:0] rx_shift;
  logic [7:0] rx_byte;
  logic       byte_done;
  logic       load_reply;
  logic [7:0] tx_shift;

  always_ff @(posedge clk) begin
    if (reset) begin
      sck_sync  <= 3'b000;
      mosi_sync <= 2'b00;
      ss_sync   <= 2'b11;
    end else begin
      sck_sync  <= {sck_sync[1:0], sck};
      mosi_sync <= {mosi_sync[0], mosi};
      ss_sync   <= {ss_sync[0], ss_n};
    end
  end

  assign active    = ~ss_sync[1];
  assign sck_rise  = active & sck_sync[1] & ~sck_sync[2];
  assign sck_fall  = active & ~sck_sync[1] & sck_sync[2];
  assign rx_byte   = {rx_shift, mosi_sync[1]};
  assign byte_done = sck_rise && (bit_cnt == 3'd7);

  ////////////////////////////////////////////////////////////////////////////
  // receive side
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      bit_cnt     <= 3'd0;
      byte_cnt    <= '0;
      cmd_ready   <= 1'b0;
      param_ready <= 1'b0;
      load_reply  <= 1'b0;
      cmd_data    <= '0;
    end else begin
      cmd_ready   <= byte_done && (byte_cnt == '0);
      param_ready <= byte_done && (byte_cnt != '0);
      load_reply  <= cmd_ready | param_ready;
      if (!active) begin
        bit_cnt  <= 3'd0;
        byte_cnt <= '0;
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 3'd1;
        // saturate on very long frames
        if (byte_done && (byte_cnt != {BYTE_CNT_W{1'b1}})) begin
          byte_cnt <= byte_cnt + 1'b1;
        end
      end
      if (byte_done && (byte_cnt == '0)) begin
        cmd_data <= rx_byte;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sck_rise) begin
      rx_shift <= rx_byte[6:0];
    end
    if (byte_done && (byte_cnt != '0)) begin
      param_data <= rx_byte;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // transmit side
  ////////////////////////////////////////////////////////////////////////////
  // first falling edge of a byte presents the msb of the loaded reply
  always_ff @(posedge clk) begin
    if (reset) begin
      tx_shift <= 8'h00;
      miso     <= 1'b0;
    end else if (!active) begin
      tx_shift <= 8'h00;
      miso     <= 1'b0;
    end else if (load_reply) begin
      tx_shift <= reply_data;
    end else if (sck_fall) begin
      miso     <= tx_shift[7];
      tx_shift <= {tx_shift[6:0], 1'b0};
    end
  end

endmodule

// File: rtl/mcu_cmd_pkg.sv
package mcu_cmd_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths and timing
  ////////////////////////////////////////////////////////////////////////////
  localparam int ADDR_W           = 24;
  localparam int BYTE_CNT_W       = 8;
  localparam int NUM_FLAG_BANKS   = 2;
  localparam int FREQ_W           = 32;
  localparam int FREQ_GATE_CYCLES = 1000;
  localparam int FREQ_GATE_W      = $clog2(FREQ_GATE_CYCLES);

  localparam logic [7:0] SPI_ID = 8'hA5;

  ////////////////////////////////////////////////////////////////////////////
  // command codes
  ////////////////////////////////////////////////////////////////////////////
  // groups in upper nibble
  localparam logic [3:0] GRP_SET_ADDR  = 4'h0;
  localparam logic [3:0] GRP_ROM_MASK  = 4'h1;
  localparam logic [3:0] GRP_SAVE_MASK = 4'h2;
  localparam logic [3:0] GRP_MAPPER    = 4'h3;
  localparam logic [3:0] GRP_MEM_READ  = 4'h8;
  localparam logic [3:0] GRP_MEM_WRITE = 4'h9;
  localparam logic [3:0] GRP_FLAGS     = 4'hC;

  // full byte codes
  localparam logic [7:0] CMD_FEATURES  = 8'hED;
  localparam logic [7:0] CMD_GET_ID    = 8'hF0;
  localparam logic [7:0] CMD_GET_FLAGS = 8'hF1;
  localparam logic [7:0] CMD_GET_FREQ  = 8'hFE;
  localparam logic [7:0] CMD_ECHO      = 8'hFF;

  // auto-increment in memory command sub nibble
  localparam int INC_BIT = 3;

  typedef struct packed {
    logic [3:0] grp;
    logic [3:0] sub;
  } cmd_split_t;

  typedef union packed {
    logic [7:0] raw;
    cmd_split_t split;
  } cmd_word_t;

endpackage
